// File: source/arb_pkg.sv
// ************************************************************
// Shared widths, port count and gap length of the arbiter
// Typedefs for port index, beat data, keep and gap counter
// Arbiter phase enum
// ************************************************************

package arb_pkg;

  localparam int num_ports  = 8;
  localparam int data_w     = 8;

  // Idle cycles after each frame, 0 skips the gap phase
  localparam int gap_cycles = 2;

  typedef logic [2:0]        port_idx_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [0:0]        keep_t;
  typedef logic [1:0]        gap_cnt_t;

  typedef enum logic [1:0] {
    phase_idle,
    phase_frame,
    phase_gap
  } phase_e;

endpackage

// File: source/arb_ctrl_if.sv
// ************************************************************
// Control links between the arbiter FSM, gap timer and
// port selector
// ************************************************************

`timescale 1ns/10ps

interface arb_ctrl_if ();

  arb_pkg::phase_e phase;
  logic            beat_accept;
  logic            beat_last;
  logic            gap_start;
  logic            gap_done;

  modport fsm (
    input  beat_accept, beat_last, gap_done,
    output phase, gap_start
  );

  modport selector (
    input  phase,
    output beat_accept, beat_last
  );

  modport timer (
    input  gap_start,
    output gap_done
  );

endinterface

// File: source/arb_fsm.sv
// ************************************************************
// Arbiter FSM with idle, frame and gap phases
// Raises the gap timer start on an accepted last beat
// ************************************************************

`timescale 1ns/10ps

module arb_fsm (
  input logic      clk,
  input logic      rstn,
  arb_ctrl_if.fsm  ctrl
);

  arb_pkg::phase_e phase;
  arb_pkg::phase_e next_phase;
  arb_pkg::phase_e end_phase;
  logic            last_accept;

  assign last_accept = ctrl.beat_accept & ctrl.beat_last;

  // Phase after a frame ends
  assign end_phase = (arb_pkg::gap_cycles != 0) ? arb_pkg::phase_gap : arb_pkg::phase_idle;

  always_comb begin
    next_phase = phase;
    case (phase)
      arb_pkg::phase_idle: begin
        if (last_accept) begin
          next_phase = end_phase;
        end else if (ctrl.beat_accept) begin
          next_phase = arb_pkg::phase_frame;
        end
      end
      arb_pkg::phase_frame: begin
        if (last_accept) begin
          next_phase = end_phase;
        end
      end
      arb_pkg::phase_gap: begin
        if (ctrl.gap_done) begin
          next_phase = arb_pkg::phase_idle;
        end
      end
      default: next_phase = arb_pkg::phase_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      phase <= arb_pkg::phase_idle;
    end else begin
      phase <= next_phase;
    end
  end

  assign ctrl.phase     = phase;
  assign ctrl.gap_start = last_accept & (arb_pkg::gap_cycles != 0);

  // Gap is entered only right after an accepted last beat
  a_gap_entry: assert property (@(posedge clk) disable iff (!rstn)
    (phase != arb_pkg::phase_gap) ##1 (phase == arb_pkg::phase_gap)
    |-> $past(ctrl.beat_accept && ctrl.beat_last));

  // Selector must block all transfers during the gap
  a_no_beat_in_gap: assert property (@(posedge clk) disable iff (!rstn)
    (phase == arb_pkg::phase_gap) |-> !ctrl.beat_accept);

endmodule

// File: source/gap_timer.sv
// ************************************************************
// Down-counter for the inter-frame gap
// ************************************************************

`timescale 1ns/10ps

module gap_timer (
  input logic       clk,
  input logic       rstn,
  arb_ctrl_if.timer ctrl
);

  arb_pkg::gap_cnt_t cnt;

  // Loaded as the last beat is taken, so the final gap cycle
  // is the one where the count sits at zero
  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt <= '0;
    end else if (ctrl.gap_start) begin
      cnt <= arb_pkg::gap_cnt_t'(arb_pkg::gap_cycles - 1);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign ctrl.gap_done = (cnt == '0);

  // Start only with a nonzero gap and the previous count run out
  a_no_wrap: assert property (@(posedge clk) disable iff (!rstn)
    ctrl.gap_start |-> (arb_pkg::gap_cycles != 0) && ctrl.gap_done);

endmodule

// File: source/port_select.sv
// ************************************************************
// Priority encoder and grant register for the input ports
// Output stream mux and ready demux
// ************************************************************

`timescale 1ns/10ps

module port_select (
  input  logic                                        clk,
  input  logic                                        rstn,
  arb_ctrl_if.selector                                ctrl,
  input  arb_pkg::data_t [arb_pkg::num_ports-1:0]     s_tdata,
  input  arb_pkg::keep_t [arb_pkg::num_ports-1:0]     s_tkeep,
  input  logic           [arb_pkg::num_ports-1:0]     s_tvalid,
  input  logic           [arb_pkg::num_ports-1:0]     s_tlast,
  output logic           [arb_pkg::num_ports-1:0]     s_tready,
  output arb_pkg::data_t                              m_tdata,
  output arb_pkg::keep_t                              m_tkeep,
  output logic                                        m_tvalid,
  output logic                                        m_tlast,
  input  logic                                        m_tready
);

  arb_pkg::port_idx_t enc_idx;
  arb_pkg::port_idx_t grant;
  arb_pkg::port_idx_t sel;
  logic               any_valid;
  logic               active;
  logic               accept;

  assign any_valid = |s_tvalid;

  // Highest numbered valid port wins
  // Falls back to port 7 with no valid port
  always_comb begin
    enc_idx = arb_pkg::port_idx_t'(arb_pkg::num_ports - 1);
    for (int i = 0; i < arb_pkg::num_ports; i++) begin
      if (s_tvalid[i]) begin
        enc_idx = arb_pkg::port_idx_t'(i);
      end
    end
  end

  // Locked choice for the rest of the frame
  always_ff @(posedge clk) begin
    if (!rstn) begin
      grant <= arb_pkg::port_idx_t'(arb_pkg::num_ports - 1);
    end else if (accept && ctrl.phase == arb_pkg::phase_idle) begin
      grant <= enc_idx;
    end
  end

  assign sel = (ctrl.phase == arb_pkg::phase_frame) ? grant : enc_idx;

  always_comb begin
    case (ctrl.phase)
      arb_pkg::phase_idle:  active = any_valid;
      arb_pkg::phase_frame: active = 1'b1;
      default:              active = 1'b0;
    endcase
  end

  // Payload follows the selected port even when blocked
  assign m_tdata  = s_tdata[sel];
  assign m_tkeep  = s_tkeep[sel];
  assign m_tlast  = s_tlast[sel];
  assign m_tvalid = active & s_tvalid[sel];

  always_comb begin
    s_tready = '0;
    if (active) begin
      s_tready[sel] = m_tready;
    end
  end

  assign accept           = m_tvalid & m_tready;
  assign ctrl.beat_accept = accept;
  assign ctrl.beat_last   = accept & m_tlast;

  // Only the port in use may see ready
  a_ready_onehot: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0(s_tready));

endmodule

// File: source/frame_arbiter.sv
// ************************************************************
// Eight-port fixed-priority Ethernet frame arbiter, top level
// FSM, gap timer and port selector joined by the control link
// ************************************************************

`timescale 1ns/10ps

module frame_arbiter (
  input  logic                                    clk,
  input  logic                                    rstn,
  input  arb_pkg::data_t [arb_pkg::num_ports-1:0] s_tdata,
  input  arb_pkg::keep_t [arb_pkg::num_ports-1:0] s_tkeep,
  input  logic           [arb_pkg::num_ports-1:0] s_tvalid,
  input  logic           [arb_pkg::num_ports-1:0] s_tlast,
  output logic           [arb_pkg::num_ports-1:0] s_tready,
  output arb_pkg::data_t                          m_tdata,
  output arb_pkg::keep_t                          m_tkeep,
  output logic                                    m_tvalid,
  output logic                                    m_tlast,
  input  logic                                    m_tready
);

  arb_ctrl_if i_ctrl ();

  arb_fsm i_fsm (
    .clk  (clk),
    .rstn (rstn),
    .ctrl (i_ctrl.fsm)
  );

  gap_timer i_gap_timer (
    .clk  (clk),
    .rstn (rstn),
    .ctrl (i_ctrl.timer)
  );

  // Stream path is combinational end to end
  port_select i_port_select (
    .clk      (clk),
    .rstn     (rstn),
    .ctrl     (i_ctrl.selector),
    .s_tdata  (s_tdata),
    .s_tkeep  (s_tkeep),
    .s_tvalid (s_tvalid),
    .s_tlast  (s_tlast),
    .s_tready (s_tready),
    .m_tdata  (m_tdata),
    .m_tkeep  (m_tkeep),
    .m_tvalid (m_tvalid),
    .m_tlast  (m_tlast),
    .m_tready (m_tready)
  );

endmodule

// File: verif/tb_frame_arbiter.sv
// ************************************************************
// Testbench for the eight-port frame arbiter
// Stimulus table, port sources, cycle model and checks
// ************************************************************

`timescale 1ns/10ps

module tb_frame_arbiter;

  typedef struct {
    string      name;
    logic [7:0] mask;
    int         len;
    bit         bp;
    int         late;
  } row_t;

  logic                                    clk;
  logic                                    rstn;
  arb_pkg::data_t [arb_pkg::num_ports-1:0] s_tdata;
  arb_pkg::keep_t [arb_pkg::num_ports-1:0] s_tkeep;
  logic           [arb_pkg::num_ports-1:0] s_tvalid;
  logic           [arb_pkg::num_ports-1:0] s_tlast;
  logic           [arb_pkg::num_ports-1:0] s_tready;
  arb_pkg::data_t                          m_tdata;
  arb_pkg::keep_t                          m_tkeep;
  logic                                    m_tvalid;
  logic                                    m_tlast;
  logic                                    m_tready;

  row_t        rows[$];
  logic [31:0] lfsr_state = 32'h448d1ea7;
  int          errors = 0;
  int          test_errors = 0;
  int          failed_tests = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 1000000;

  // Source state per port
  bit started[8];
  bit done[8];
  int beat[8];
  bit keep_mem[8][32];

  frame_arbiter i_dut (
    .clk      (clk),
    .rstn     (rstn),
    .s_tdata  (s_tdata),
    .s_tkeep  (s_tkeep),
    .s_tvalid (s_tvalid),
    .s_tlast  (s_tlast),
    .s_tready (s_tready),
    .m_tdata  (m_tdata),
    .m_tkeep  (m_tkeep),
    .m_tvalid (m_tvalid),
    .m_tlast  (m_tlast),
    .m_tready (m_tready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  // Galois LFSR, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'hA300_0000;
    end
    return out;
  endfunction

  function automatic arb_pkg::data_t data_byte(input int p, input int b);
    return {p[2:0], b[4:0]};
  endfunction

  task automatic compare(input string test, input string what,
                         input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected %0h, actual %0h", test, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic add_row(input string name, input logic [7:0] mask, input int len,
                         input bit bp, input int late);
    row_t r;
    r.name = name;
    r.mask = mask;
    r.len  = len;
    r.bp   = bp;
    r.late = late;
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row("idle_after_reset", 8'h00, 0, 1'b0, -1);
    for (int p = 0; p < 8; p++) begin
      add_row($sformatf("single_p%0d", p), 8'h01 << p, p + 2, 1'b0, -1);
    end
    add_row("priority_all", 8'hff, 4, 1'b0, -1);
    add_row("priority_mixed", 8'h5a, 3, 1'b0, -1);
    add_row("single_beat", 8'hc3, 1, 1'b0, -1);
    add_row("no_preempt", 8'h01, 6, 1'b0, 6);
    add_row("no_preempt_mid", 8'h14, 5, 1'b0, 7);
    add_row("backpressure_all", 8'hff, 5, 1'b1, -1);
    add_row("backpressure_late", 8'h03, 8, 1'b1, 5);
  endtask

  // Worst case per row with slack for random stalls
  function automatic int compute_limit();
    int total;
    int frames;
    total = 24;
    foreach (rows[i]) begin
      frames = $countones(rows[i].mask) + ((rows[i].late >= 0) ? 1 : 0);
      total += 4 + frames * (rows[i].len * (rows[i].bp ? 8 : 1) + arb_pkg::gap_cycles + 2);
    end
    return total * 2;
  endfunction

  task automatic drive_sources(input int len);
    for (int p = 0; p < 8; p++) begin
      s_tvalid[p] = started[p] && !done[p];
      if (s_tvalid[p]) begin
        s_tdata[p] = data_byte(p, beat[p]);
        s_tkeep[p] = keep_mem[p][beat[p]];
        s_tlast[p] = (beat[p] == len - 1);
      end else begin
        s_tdata[p] = '0;
        s_tkeep[p] = '0;
        s_tlast[p] = 1'b0;
      end
    end
  endtask

  task automatic run_test(input row_t r);
    logic [7:0] req;
    logic [7:0] exp_ready;
    logic       exp_valid;
    bit         in_frame;
    bit         any_pend;
    bit         late_up;
    bit         first_seen;
    bit         fin;
    int         frame_port;
    int         exp_port;
    int         nxt;
    int         gap_left;
    int         cyc;
    int         frames;
    req = r.mask;
    if (r.late >= 0) begin
      req[r.late] = 1'b1;
    end
    for (int p = 0; p < 8; p++) begin
      started[p] = r.mask[p];
      done[p] = !req[p];
      beat[p] = 0;
      for (int b = 0; b < r.len; b++) begin
        keep_mem[p][b] = lfsr_bit();
      end
    end
    in_frame = 1'b0;
    late_up = 1'b0;
    first_seen = 1'b0;
    fin = 1'b0;
    frame_port = 0;
    gap_left = 0;
    cyc = 0;
    frames = 0;
    test_errors = 0;
    while (!fin) begin
      @(negedge clk);
      // Late port joins once the first frame is under way
      if (r.late >= 0 && first_seen && !late_up) begin
        started[r.late] = 1'b1;
        late_up = 1'b1;
      end
      drive_sources(r.len);
      m_tready = r.bp ? lfsr_bit() : 1'b1;
      #1;
      any_pend = 1'b0;
      nxt = 0;
      for (int p = 0; p < 8; p++) begin
        if (started[p] && !done[p]) begin
          any_pend = 1'b1;
          nxt = p;
        end
      end
      exp_port = in_frame ? frame_port : nxt;
      if (gap_left > 0 || !any_pend) begin
        exp_valid = 1'b0;
        exp_ready = 8'h00;
      end else begin
        exp_valid = 1'b1;
        exp_ready = m_tready ? (8'h01 << exp_port) : 8'h00;
      end
      compare(r.name, "m_tvalid", 32'(exp_valid), 32'(m_tvalid));
      compare(r.name, "s_tready", 32'(exp_ready), 32'(s_tready));
      if (gap_left > 0) begin
        gap_left--;
      end else if (exp_valid && m_tready) begin
        compare(r.name, "m_tdata", 32'(data_byte(exp_port, beat[exp_port])), 32'(m_tdata));
        compare(r.name, "m_tkeep", 32'(keep_mem[exp_port][beat[exp_port]]), 32'(m_tkeep));
        compare(r.name, "m_tlast", 32'(beat[exp_port] == r.len - 1), 32'(m_tlast));
        first_seen = 1'b1;
        in_frame = 1'b1;
        frame_port = exp_port;
        if (beat[exp_port] == r.len - 1) begin
          done[exp_port] = 1'b1;
          in_frame = 1'b0;
          gap_left = arb_pkg::gap_cycles;
          frames++;
        end
        beat[exp_port]++;
      end
      cyc++;
      fin = (cyc >= 4) && !in_frame && (gap_left == 0) && !any_pend
            && (r.late < 0 || late_up);
      if (fin) begin
        for (int p = 0; p < 8; p++) begin
          fin = fin && done[p];
        end
      end
    end
    if (test_errors != 0) begin
      failed_tests++;
    end
    $display("%-18s %0d frames, %0d cycles, %s", r.name, frames, cyc,
             (test_errors == 0) ? "ok" : "FAILED");
  endtask

  initial begin
    rstn = 1'b0;
    s_tdata = '0;
    s_tkeep = '0;
    s_tvalid = '0;
    s_tlast = '0;
    m_tready = 1'b0;
    build_table();
    cycle_limit = compute_limit();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    foreach (rows[i]) begin
      run_test(rows[i]);
    end
    $display("%0d tests, %0d failing, %0d mismatches", rows.size(), failed_tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: frame_arbiter.f
source/arb_pkg.sv
source/arb_ctrl_if.sv
source/arb_fsm.sv
source/gap_timer.sv
source/port_select.sv
source/frame_arbiter.sv
verif/tb_frame_arbiter.sv

// File: Makefile
# Verilator build and run for the frame arbiter

VERILATOR ?= verilator
TOP       ?= tb_frame_arbiter
FILELIST  ?= frame_arbiter.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: test clean help

test: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Test passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"
